// ==== verification/core_input.hex ====
// Whitespace separated 32-bit words in order: program length, program words,
// 16 data memory words, store count, store address and data pairs, halt PC
00000047
f0f00093 03500113                                      // x1 = -241  x2 = 0x35
002081b3 02302e23 402081b3 02302e23 0020f1b3 02302e23  // ADD SUB AND
0020e1b3 02302e23 0020c1b3 02302e23 002091b3 02302e23  // OR XOR SLL
0020d1b3 02302e23 4020d1b3 02302e23 0020a1b3 02302e23  // SRL SRA SLT
0020b1b3 02302e23 4040d193 02302e23 7ff0c193 02302e23  // SLTU SRAI XORI
f380a193 02302e23                                      // SLTI
00802203 11120213 00402623 00c02283 02502e23           // Load, modify, store, read back
00108463 00130313 00109463 00230313 0020c463 00430313  // Branch group on x1 x2
0020d463 00830313 0020e463 01030313 0020f463 02030313
02602e23
00208463 00138393 00209463 00238393 00114463 00438393  // Branch group on x2 x1
00115463 00838393 00116463 01038393 00117463 02038393
02702e23
abcde437 02802e23 00001497 02902e23                    // LUI and AUIPC
0080056f 02102e23 02a02e23                             // JAL over a bad store
00000617 00d605e7 02102e23 02b02e23                    // JALR over a bad store
0000006f                                               // Halt loop
a5a50000 a5a50004 12345678 a5a5000c a5a50010 a5a50014 a5a50018 a5a5001c
a5a50020 a5a50024 a5a50028 a5a5002c a5a50030 a5a50034 a5a50038 a5a5003c
00000015
0000003c ffffff44 0000003c fffffeda 0000003c 00000005
0000003c ffffff3f 0000003c ffffff3a 0000003c e1e00000
0000003c 000007ff 0000003c ffffffff 0000003c 00000001
0000003c 00000000 0000003c fffffff0 0000003c fffff8f0
0000003c 00000001 0000000c 12345789 0000003c 12345789
0000003c 0000001a 0000003c 00000025 0000003c abcde000
0000003c 000010f4 0000003c 00000100 0000003c 00000110
00000118

// ==== list.f ====
source/rv_pkg.sv
source/fetch_unit.sv
source/instr_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/riscv_core.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module core_tb -o core_tb
./obj_dir/core_tb

// ==== verification/core_tb.sv ====
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  localparam int max_cycles = 500;             // Program retires in under 100

  logic      clk;
  logic      reset;
  addr_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  word_t stim [256];                           // Raw image of the data file
  word_t imem [128];
  word_t dmem [16];
  addr_t exp_addr [32];                        // Expected stores in order
  word_t exp_data [32];
  int    prog_len;
  int    store_count;
  int    stores_seen;
  addr_t halt_pc;

  riscv_core uut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                    // 100 ns period
  end

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  assign imem_data  = imem[imem_addr[8:2]];    // Zero-latency fetch
  assign dmem_rdata = dmem[dmem_req.addr[5:2]];

  always @(posedge clk) begin
    if (dmem_req.write) begin
      dmem[dmem_req.addr[5:2]] <= dmem_req.wdata;
    end
  end

  // ----------------------------------------
  // Compare and failure tasks
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(string name, addr_t actual, addr_t expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  // Program, data memory, store list and halt PC from one file
  task automatic load_test_data();
    int pos;
    $readmemh("verification/core_input.hex", stim);
    if ($isunknown(stim[0]) || stim[0] > 128) begin
      $display("Data file missing or program longer than 128 words");
      stop_with_failure();
    end
    prog_len = int'(stim[0]);
    for (int i = 0; i < 128; i++) begin
      imem[i] = (i < prog_len) ? stim[1 + i] : '0;   // Opcode 0 acts as no-op
    end
    pos = 1 + prog_len;
    for (int i = 0; i < 16; i++) begin
      dmem[i] <= stim[pos + i];
    end
    pos = pos + 16;
    if (stim[pos] > 32) begin
      $display("Data file lists more than 32 expected stores");
      stop_with_failure();
    end
    store_count = int'(stim[pos]);
    for (int i = 0; i < store_count; i++) begin
      exp_addr[i] = stim[pos + 1 + 2 * i];
      exp_data[i] = stim[pos + 2 + 2 * i];
    end
    halt_pc = stim[pos + 1 + 2 * store_count];
  endtask

  task automatic check_reset_outputs();
    check_addr("imem_addr", imem_addr, '0);
    check_flag("dmem_req.read", dmem_req.read, 1'b0);
    check_flag("dmem_req.write", dmem_req.write, 1'b0);
  endtask

  task automatic check_store();
    if (stores_seen >= store_count) begin
      $display("Unexpected store to %h after all %0d expected stores",
               dmem_req.addr, store_count);
      stop_with_failure();
    end
    check_addr("dmem_req.addr", dmem_req.addr, exp_addr[stores_seen]);
    check_word("dmem_req.wdata", dmem_req.wdata, exp_data[stores_seen]);
    stores_seen++;
  endtask

  // Sample mid-cycle until the halt loop is fetched
  task automatic run_to_halt();
    int cycles;
    cycles = 0;
    while (imem_addr !== halt_pc) begin
      if (dmem_req.write === 1'b1) begin
        check_store();
      end
      cycles++;
      if (cycles >= max_cycles) begin
        $display("Timeout, core did not reach halt PC %h in %0d cycles", halt_pc, max_cycles);
        stop_with_failure();
      end
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    reset       = 1'b0;                        // In reset from time 0
    stores_seen = 0;
    load_test_data();
    @(posedge clk);
    @(negedge clk);
    check_reset_outputs();
    @(posedge clk);
    #1 reset = 1'b1;                           // Released after 2 edges
    @(negedge clk);
    check_reset_outputs();                     // First fetch still at 0
    run_to_halt();
    check_word("store_count", word_t'(stores_seen), word_t'(store_count));
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== verification/core_checker.sv ====
module core_checker (
  input logic              clk,
  input logic              reset,
  input rv_pkg::addr_t     imem_addr,
  input rv_pkg::dmem_req_t dmem_req
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // Bus rules
  // ----------------------------------------
  fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h not word aligned", imem_addr);

  single_access: assert property (@(posedge clk) disable iff (!reset)
    !(dmem_req.read && dmem_req.write))
    else $error("dmem read and write set together");

  access_aligned: assert property (@(posedge clk) disable iff (!reset)
    (dmem_req.read || dmem_req.write) |-> dmem_req.addr[1:0] == 2'b00)
    else $error("dmem addr %h not word aligned", dmem_req.addr);

  quiet_in_reset: assert property (@(posedge clk) !reset |-> !dmem_req.write)
    else $error("dmem write during reset");  // No stores before release

endmodule

bind riscv_core core_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .imem_addr (imem_addr),
  .dmem_req  (dmem_req)
);

// ==== source/riscv_core.sv ====
module riscv_core (
  input  logic              clk,
  input  logic              reset,
  output rv_pkg::addr_t     imem_addr,
  input  rv_pkg::word_t     imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata
);

  import rv_pkg::*;

  addr_t    pc;
  addr_t    pc_plus4;
  addr_t    target;
  logic     redirect;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    wb_data;
  ctrl_t    ctrl;

  assign imem_addr = pc;                 // Fetch address straight from PC

  // ----------------------------------------
  // Fetch and decode
  // ----------------------------------------
  fetch_unit u_fetch (
    .clk      (clk),
    .reset    (reset),
    .redirect (redirect),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  instr_decoder u_decode (
    .instr (imem_data),
    .rs1   (rs1),
    .rs2   (rs2),
    .ctrl  (ctrl)
  );

  // ----------------------------------------
  // Registers and execute
  // ----------------------------------------
  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (ctrl.rd),
    .write    (ctrl.reg_write),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit u_exec (
    .ctrl       (ctrl),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .redirect   (redirect),
    .target     (target),
    .wb_data    (wb_data)
  );

endmodule

// ==== source/execute_unit.sv ====
module execute_unit (
  input  rv_pkg::ctrl_t     ctrl,
  input  rv_pkg::addr_t     pc,
  input  rv_pkg::addr_t     pc_plus4,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              redirect,
  output rv_pkg::addr_t     target,
  output rv_pkg::word_t     wb_data
);

  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t sum;                                   // Also address and JALR target
  word_t alu_result;
  addr_t branch_target;
  logic  taken;

  assign op_a = ctrl.src_a_pc ? pc : rs1_data;
  assign op_b = ctrl.src_b_imm ? ctrl.imm : rs2_data;
  assign sum  = op_a + op_b;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = sum;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_AND:  alu_result = op_a & op_b;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SLL:  alu_result = op_a << op_b[4:0];
      ALU_SRL:  alu_result = op_a >> op_b[4:0];
      ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_SLT:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      default:  alu_result = op_b;            // PASS_B for LUI
    endcase
  end

  // ----------------------------------------
  // Branch condition, rs1 against rs2
  // ----------------------------------------
  always_comb begin
    case (ctrl.funct3)
      3'b000:  taken = (rs1_data == rs2_data);                   // BEQ
      3'b001:  taken = (rs1_data != rs2_data);                   // BNE
      3'b100:  taken = ($signed(rs1_data) <  $signed(rs2_data)); // BLT
      3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
      3'b110:  taken = (rs1_data <  rs2_data);                   // BLTU
      3'b111:  taken = (rs1_data >= rs2_data);                   // BGEU
      default: taken = 1'b0;
    endcase
  end

  assign branch_target = pc + ctrl.imm;         // Branches and JAL
  assign redirect      = ctrl.is_jump | (ctrl.is_branch & taken);
  assign target        = (ctrl.is_jump && !ctrl.src_a_pc) ?
                         {sum[xlen-1:1], 1'b0} : branch_target;  // JALR clears bit 0

  assign dmem_req = '{addr: sum, wdata: rs2_data, read: ctrl.mem_read, write: ctrl.mem_write};

  // Writeback source
  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = dmem_rdata;
      WB_PC4:  wb_data = pc_plus4;              // Link value
      default: wb_data = alu_result;
    endcase
  end

endmodule

// ==== source/register_file.sv ====
module register_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             write,
  input  rv_pkg::word_t    wdata,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  import rv_pkg::*;

  word_t regs [reg_count];

  // Write port, x0 never written
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];   // x0 hardwired to zero
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/instr_decoder.sv ====
module instr_decoder (
  input  rv_pkg::word_t    instr,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::ctrl_t    ctrl
);

  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;                             // funct7 bit 5, SUB and SRA
  alu_op_t    arith_op;                        // Shared by OP and OP_IMM
  imm_kind_t  imm_kind;
  word_t      imm;
  logic       known;                           // Opcode is supported

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // ----------------------------------------
  // funct3 to ALU operation
  // ----------------------------------------
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD; // No SUBI
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // Immediate format per opcode
  always_comb begin
    case (opcode)
      OPC_STORE:          imm_kind = IMM_S;
      OPC_BRANCH:         imm_kind = IMM_B;
      OPC_JAL:            imm_kind = IMM_J;
      OPC_LUI, OPC_AUIPC: imm_kind = IMM_U;
      default:            imm_kind = IMM_I;   // ALU imm, loads, JALR
    endcase
  end

  // ----------------------------------------
  // Immediate generation
  // ----------------------------------------
  always_comb begin
    case (imm_kind)
      IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
      IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm = {instr[31:12], 12'b0};    // Upper 20 bits, low zero
      IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // ----------------------------------------
  // Control bundle
  // ----------------------------------------
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;                     // Address and link arithmetic
    ctrl.wb_sel = WB_ALU;
    known       = 1'b1;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      OPC_LOAD: begin
        known          = (funct3 == 3'b010);   // LW only
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.wb_sel    = WB_LOAD;
      end
      OPC_STORE: begin
        known          = (funct3 == 3'b010);   // SW only
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OPC_BRANCH: begin
        known          = (funct3[2:1] != 2'b01); // 010 and 011 undefined
        ctrl.is_branch = 1'b1;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = WB_PC4;
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.src_b_imm = 1'b1;                 // rs1 + imm
        ctrl.wb_sel    = WB_PC4;
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
      end
      default: known = 1'b0;
    endcase
    ctrl.funct3 = funct3;
    ctrl.rd     = instr[11:7];
    ctrl.imm    = imm;
    if (!known) begin
      ctrl = '0;                               // Unsupported, behaves as no-op
    end
  end

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          redirect,      // Taken branch or jump
  input  rv_pkg::addr_t target,        // Redirect destination
  output rv_pkg::addr_t pc,
  output rv_pkg::addr_t pc_plus4       // Sequential next PC, also the link value
);

  assign pc_plus4 = pc + 32'd4;

  // ----------------------------------------
  // PC register
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      pc <= '0;                        // Boot from address 0
    end else if (redirect) begin
      pc <= target;
    end else begin
      pc <= pc_plus4;
    end
  end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int xlen      = 32;                      // Data path width
  localparam int reg_count = 32;                      // Architectural registers

  typedef logic [xlen-1:0]              word_t;       // Register and memory data
  typedef logic [xlen-1:0]              addr_t;       // Byte address
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;    // Register index

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,                          // R-type ALU
    OPC_OP_IMM = 7'b0010011,                          // I-type ALU
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_PASS_B                                        // LUI, operand B straight through
  } alu_op_t;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_t;

  typedef enum logic [1:0] {
    WB_ALU,                                           // ALU result
    WB_LOAD,                                          // Data memory word
    WB_PC4                                            // Link address
  } wb_sel_t;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  typedef struct packed {
    logic       reg_write;                            // Write rd at clock edge
    logic       src_a_pc;                             // Operand A is pc
    logic       src_b_imm;                            // Operand B is imm
    alu_op_t    alu_op;
    wb_sel_t    wb_sel;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       is_jump;                              // JAL or JALR
    logic [2:0] funct3;                               // Branch condition
    reg_idx_t   rd;
    word_t      imm;                                  // Sign-extended immediate
  } ctrl_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  read;
    logic  write;
  } dmem_req_t;

endpackage
